// File: list.f
+incdir+sim
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/writeback_unit.sv
rtl/educore_lite.sv
sim/tb_educore_lite.sv

// File: Makefile
SIM   = verilator
FLAGS = --binary --timing
TOP   = tb_educore_lite
FLIST = list.f
MDIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator and run the testbench"
	@echo "  make clean  remove the build directory"
	@echo "  make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(MDIR)
	@out=$$(./$(MDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(MDIR)

// File: sim/tb_tests.svh
//----------------------------------------------------------
// A64 encoders and directed tests, included in the testbench
// Programs keep three NOPs between dependent instructions
//----------------------------------------------------------

	// Operands of the arithmetic program
	logic [11:0]     imm_a;
	logic [11:0]     imm_b;
	logic [11:0]     imm_c;
	logic [11:0]     off_b;
	logic [11:0]     off_c;
	core_pkg::xlen_t exp_b;
	core_pkg::xlen_t exp_c;

	//----------------------------------------------------------
	// Encoders, 64-bit forms only
	function automatic core_pkg::instr_t add_imm(core_pkg::reg_addr_t rd,
		core_pkg::reg_addr_t rn, logic [11:0] imm, logic sh);
		// sf=1 op=0 S=0
		return {3'b100, 6'b100010, sh, imm, rn, rd};
	endfunction

	function automatic core_pkg::instr_t sub_imm(core_pkg::reg_addr_t rd,
		core_pkg::reg_addr_t rn, logic [11:0] imm, logic sh);
		// sf=1 op=1 S=0
		return {3'b110, 6'b100010, sh, imm, rn, rd};
	endfunction

	function automatic core_pkg::instr_t ldr_uimm(core_pkg::reg_addr_t rt,
		core_pkg::reg_addr_t rn, logic [11:0] imm);
		// size=11 V=0 opc=01
		return {2'b11, 3'b111, 1'b0, 2'b01, 2'b01, imm, rn, rt};
	endfunction

	function automatic core_pkg::instr_t str_uimm(core_pkg::reg_addr_t rt,
		core_pkg::reg_addr_t rn, logic [11:0] imm);
		// opc=00 for the store
		return {2'b11, 3'b111, 1'b0, 2'b01, 2'b00, imm, rn, rt};
	endfunction

	task automatic clear_memories();
		foreach (imem[i]) begin
			imem[i] = NOP_WORD;
		end
		dmem.delete();
	endtask

	//----------------------------------------------------------
	// Behaviour 1
	task automatic reset_and_fetch();
		int cycles;
		int k;
		clear_memories();
		reset_dut();
		cycles = 0;
		@(posedge clk);
		while (!instruction_memory_en && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (!instruction_memory_en) begin
			$display("Timeout waiting for the instruction memory enable after reset");
			timeout_count++;
			return;
		end
		// One word per run cycle from address 0
		for (k = 0; k < 8; k++) begin
			check_word("instruction_memory_a", core_pkg::xlen_t'(4 * k), instruction_memory_a);
			@(posedge clk);
		end
	endtask

	// x1 = imm_a, x2 = x1 - imm_b, x3 = x1 + imm_c LSL 12
	task automatic arith_program();
		imm_a = 12'($urandom);
		imm_b = 12'($urandom);
		imm_c = 12'($urandom);
		off_b = 12'($urandom % 256);
		off_c = off_b + 12'd1 + 12'($urandom % 256);
		exp_b = core_pkg::xlen_t'(imm_a) - core_pkg::xlen_t'(imm_b);
		exp_c = core_pkg::xlen_t'(imm_a) + (core_pkg::xlen_t'(imm_c) << 12);
		clear_memories();
		imem[0]  = add_imm(5'd1, 5'd31, imm_a, 1'b0);
		imem[4]  = sub_imm(5'd2, 5'd1, imm_b, 1'b0);
		imem[5]  = add_imm(5'd3, 5'd1, imm_c, 1'b1);
		imem[9]  = str_uimm(5'd2, 5'd31, off_b);
		imem[10] = str_uimm(5'd3, 5'd31, off_c);
	endtask

	// Base x31 reads zero, so address is offset times 8
	task automatic check_arith_stores();
		bit ok;
		wait_for_writes(2, ok);
		if (ok) begin
			check_word("data_memory_a", core_pkg::xlen_t'(off_b) << 3, wr_addr_log[0]);
			check_word("data_memory_out_v", exp_b, wr_data_log[0]);
			check_word("data_memory_a", core_pkg::xlen_t'(off_c) << 3, wr_addr_log[1]);
			check_word("data_memory_out_v", exp_c, wr_data_log[1]);
		end
	endtask

	// Behaviour 2
	task automatic arith_then_store();
		arith_program();
		reset_dut();
		check_arith_stores();
	endtask

	//----------------------------------------------------------
	// Behaviour 3
	task automatic load_then_store();
		logic [11:0]     base_imm;
		logic [11:0]     ld_off;
		logic [11:0]     st_off;
		core_pkg::xlen_t ld_addr;
		core_pkg::xlen_t word;
		bit              ok;
		base_imm = 12'($urandom % 256) << 3;
		ld_off   = 12'($urandom % 64);
		// Store area above every load address
		st_off   = 12'd512 + 12'($urandom % 64);
		ld_addr  = core_pkg::xlen_t'(base_imm) + (core_pkg::xlen_t'(ld_off) << 3);
		word     = {$urandom, $urandom};
		clear_memories();
		dmem[ld_addr] = word;
		imem[0] = add_imm(5'd5, 5'd31, base_imm, 1'b0);
		imem[4] = ldr_uimm(5'd4, 5'd5, ld_off);
		imem[8] = str_uimm(5'd4, 5'd31, st_off);
		reset_dut();
		wait_for_writes(1, ok);
		if (!ok) begin
			return;
		end
		if (rd_addr_log.size() == 0) begin
			$display("No data memory read was seen before the store");
			timeout_count++;
		end else begin
			check_word("data_memory_a", ld_addr, rd_addr_log[0]);
		end
		check_word("data_memory_a", core_pkg::xlen_t'(st_off) << 3, wr_addr_log[0]);
		check_word("data_memory_out_v", word, wr_data_log[0]);
	endtask

	// Behaviour 4, x31 drops the ADD result
	task automatic zero_reg_write();
		logic [11:0] imm;
		logic [11:0] off;
		bit          ok;
		imm = 12'($urandom % 4095) + 12'd1;
		off = 12'($urandom % 256);
		clear_memories();
		imem[0] = add_imm(5'd31, 5'd31, imm, 1'b0);
		imem[4] = str_uimm(5'd31, 5'd31, off);
		reset_dut();
		wait_for_writes(1, ok);
		if (ok) begin
			check_word("data_memory_a", core_pkg::xlen_t'(off) << 3, wr_addr_log[0]);
			check_word("data_memory_out_v", '0, wr_data_log[0]);
		end
	endtask

	//----------------------------------------------------------
	// Behaviour 5
	task automatic clock_enable_stall();
		int              cycles;
		core_pkg::xlen_t held_addr;
		logic            held_read;
		logic            held_write;
		arith_program();
		reset_dut();
		cycles = 0;
		@(posedge clk);
		// Stop with the second store on the port
		while (instruction_memory_a != 64'd48 && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (instruction_memory_a != 64'd48) begin
			$display("Timeout waiting for fetch address 48 before the stall");
			timeout_count++;
			return;
		end
		@(negedge clk);
		clk_en = 1'b0;
		@(posedge clk);
		held_addr  = instruction_memory_a;
		held_read  = data_memory_read;
		held_write = data_memory_write;
		repeat (5) begin
			@(posedge clk);
			check_word("instruction_memory_a", held_addr, instruction_memory_a);
			check_bit("data_memory_read", held_read, data_memory_read);
			check_bit("data_memory_write", held_write, data_memory_write);
		end
		@(negedge clk);
		clk_en = 1'b1;
		check_arith_stores();
	endtask

	// Behaviour 6, undefined word four slots after a store
	task automatic decode_error_halt();
		logic [11:0]     imm;
		logic [11:0]     off;
		int              cycles;
		core_pkg::xlen_t held_addr;
		imm = 12'($urandom);
		off = 12'($urandom % 256);
		clear_memories();
		imem[0] = add_imm(5'd6, 5'd31, imm, 1'b0);
		imem[4] = str_uimm(5'd6, 5'd31, off);
		// UDF #0
		imem[8] = 32'h0000_0000;
		reset_dut();
		cycles = 0;
		@(posedge clk);
		while (error_indicator != core_pkg::ERR_UNDEF && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (error_indicator != core_pkg::ERR_UNDEF) begin
			$display("Timeout waiting for the decode error on the undefined word");
			timeout_count++;
			return;
		end
		held_addr = instruction_memory_a;
		// Frozen for eight cycles with no write
		repeat (8) begin
			@(posedge clk);
			check_err("error_indicator", core_pkg::ERR_UNDEF, error_indicator);
			check_word("instruction_memory_a", held_addr, instruction_memory_a);
			check_bit("data_memory_write", 1'b0, data_memory_write);
		end
		@(negedge clk);
		if (wr_addr_log.size() != 1) begin
			$display("Expected one store before the halt, saw %0d", wr_addr_log.size());
			timeout_count++;
		end else begin
			check_word("data_memory_a", core_pkg::xlen_t'(off) << 3, wr_addr_log[0]);
			check_word("data_memory_out_v", core_pkg::xlen_t'(imm), wr_data_log[0]);
		end
	endtask

// File: sim/tb_educore_lite.sv
//----------------------------------------------------------
// Directed tests of the A64 subset core with random seed 25
// Both memories are behavioural with one cycle read latency
//----------------------------------------------------------
module tb_educore_lite;

	localparam int              WAIT_LIMIT = 60;
	localparam int              IMEM_WORDS = 64;
	localparam core_pkg::xlen_t IMEM_BYTES = 64'd256;
	// A64 HINT #0
	localparam core_pkg::instr_t NOP_WORD = 32'hD503_201F;

	logic                clk;
	logic                nreset;
	logic                clk_en;
	core_pkg::instr_t    instruction_memory_v = 32'hD503_201F;
	core_pkg::xlen_t     data_memory_in_v = '0;
	core_pkg::err_code_t error_indicator;
	core_pkg::xlen_t     instruction_memory_a;
	logic                instruction_memory_en;
	core_pkg::xlen_t     data_memory_a;
	core_pkg::xlen_t     data_memory_out_v;
	core_pkg::mem_size_t data_memory_s;
	logic                data_memory_read;
	logic                data_memory_write;

	// Memory contents and registered read data
	core_pkg::instr_t imem [0:IMEM_WORDS-1];
	core_pkg::xlen_t  dmem [core_pkg::xlen_t];
	core_pkg::instr_t imem_q = 32'hD503_201F;
	core_pkg::xlen_t  dmem_q = '0;

	// Data accesses seen on enabled cycles in arrival order
	core_pkg::xlen_t rd_addr_log [$];
	core_pkg::xlen_t wr_addr_log [$];
	core_pkg::xlen_t wr_data_log [$];

	int error_count = 0;
	int timeout_count = 0;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	educore_lite u_educore_lite (
		.clk                   (clk),
		.nreset                (nreset),
		.clk_en                (clk_en),
		.instruction_memory_v  (instruction_memory_v),
		.data_memory_in_v      (data_memory_in_v),
		.error_indicator       (error_indicator),
		.instruction_memory_a  (instruction_memory_a),
		.instruction_memory_en (instruction_memory_en),
		.data_memory_a         (data_memory_a),
		.data_memory_out_v     (data_memory_out_v),
		.data_memory_s         (data_memory_s),
		.data_memory_read      (data_memory_read),
		.data_memory_write     (data_memory_write)
	);

	function automatic core_pkg::xlen_t read_word(core_pkg::xlen_t addr);
		// Unwritten words give a pattern of their own address
		if (dmem.exists(addr)) begin
			return dmem[addr];
		end
		return addr ^ 64'hC3A5_5A3C_0FF0_9669;
	endfunction

	//----------------------------------------------------------
	// Memory models sampled on the rising edge
	always @(posedge clk) begin
		if (instruction_memory_en) begin
			if (instruction_memory_a < IMEM_BYTES) begin
				imem_q <= imem[instruction_memory_a[7:2]];
			end else begin
				imem_q <= NOP_WORD;
			end
		end
		// A64 size field of a doubleword access
		if ((data_memory_read || data_memory_write) && clk_en) begin
			check_size("data_memory_s", 2'b11, data_memory_s);
		end
		if (data_memory_read) begin
			dmem_q <= read_word(data_memory_a);
			if (clk_en) begin
				rd_addr_log.push_back(data_memory_a);
			end
		end
		if (data_memory_write) begin
			dmem[data_memory_a] = data_memory_out_v;
			// A stalled strobe repeats the same write
			if (clk_en) begin
				wr_addr_log.push_back(data_memory_a);
				wr_data_log.push_back(data_memory_out_v);
			end
		end
	end

	// Read data reaches the DUT on the falling edge
	always @(negedge clk) begin
		instruction_memory_v = imem_q;
		data_memory_in_v     = dmem_q;
	end

	//----------------------------------------------------------
	// Compare tasks
	task automatic check_word(input string name, input core_pkg::xlen_t expected,
		input core_pkg::xlen_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_err(input string name, input core_pkg::err_code_t expected,
		input core_pkg::err_code_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_size(input string name, input core_pkg::mem_size_t expected,
		input core_pkg::mem_size_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// Five reset cycles with the strobes checked low
	task automatic reset_dut();
		@(negedge clk);
		nreset = 1'b0;
		clk_en = 1'b1;
		rd_addr_log.delete();
		wr_addr_log.delete();
		wr_data_log.delete();
		repeat (5) begin
			@(posedge clk);
			check_bit("instruction_memory_en", 1'b0, instruction_memory_en);
			check_bit("data_memory_read", 1'b0, data_memory_read);
			check_bit("data_memory_write", 1'b0, data_memory_write);
			@(negedge clk);
		end
		nreset = 1'b1;
	endtask

	// Log sizes are read between rising edges
	task automatic wait_for_writes(input int count, output bit ok);
		int cycles;
		cycles = 0;
		while (wr_addr_log.size() < count && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		ok = wr_addr_log.size() >= count;
		if (!ok) begin
			$display("Timeout waiting for %0d data memory writes, only %0d seen",
				count, wr_addr_log.size());
			timeout_count++;
		end
	endtask

	`include "tb_tests.svh"

	initial begin
		void'($urandom(25));
		nreset = 1'b0;
		clk_en = 1'b0;
		reset_and_fetch();
		arith_then_store();
		load_then_store();
		zero_reg_write();
		clock_enable_stall();
		decode_error_halt();
		$display("Mismatches: %0d, timeouts and other failures: %0d",
			error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: rtl/educore_lite.sv
//----------------------------------------------------------
// Five-stage in-order core, no forwarding between stages
// Results readable four instructions later, pad with NOPs
// Unsupported encodings halt the core until reset
//----------------------------------------------------------
module educore_lite (
	input  logic                clk,
	input  logic                nreset,
	input  logic                clk_en,
	input  core_pkg::instr_t    instruction_memory_v,
	input  core_pkg::xlen_t     data_memory_in_v,
	output core_pkg::err_code_t error_indicator,
	output core_pkg::xlen_t     instruction_memory_a,
	output logic                instruction_memory_en,
	output core_pkg::xlen_t     data_memory_a,
	output core_pkg::xlen_t     data_memory_out_v,
	output core_pkg::mem_size_t data_memory_s,
	output logic                data_memory_read,
	output logic                data_memory_write
);

	// Pipeline enable and fetched word
	logic                run;
	core_pkg::instr_t    instr;
	core_pkg::err_code_t decode_err;

	// Register file read side
	core_pkg::reg_addr_t rn_addr;
	core_pkg::reg_addr_t rt_addr;
	core_pkg::xlen_t     rn_value;
	core_pkg::xlen_t     rt_value;

	// Decode to execute
	core_pkg::xlen_t     ex_base;
	core_pkg::xlen_t     ex_imm;
	core_pkg::xlen_t     ex_store_value;
	core_pkg::reg_addr_t ex_rd_addr;
	logic                ex_sub;
	logic                ex_write_en;
	logic                ex_load;
	logic                ex_store;

	// Execute to writeback
	core_pkg::xlen_t     mem_result;
	core_pkg::reg_addr_t mem_rd_addr;
	logic                mem_write_en;
	logic                mem_load;

	// Register file write side
	logic                wr_en;
	core_pkg::reg_addr_t wr_addr;
	core_pkg::xlen_t     wr_data;

	assign error_indicator = decode_err;

	fetch_unit u_fetch_unit (
		.clk                   (clk),
		.nreset                (nreset),
		.clk_en                (clk_en),
		.decode_err            (decode_err),
		.instruction_memory_v  (instruction_memory_v),
		.run                   (run),
		.instruction_memory_a  (instruction_memory_a),
		.instruction_memory_en (instruction_memory_en),
		.instr                 (instr),
		.instr_pc_valid        ()
	);

	decode_unit u_decode_unit (
		.clk            (clk),
		.nreset         (nreset),
		.run            (run),
		.instr          (instr),
		.rn_value       (rn_value),
		.rt_value       (rt_value),
		.rn_addr        (rn_addr),
		.rt_addr        (rt_addr),
		.decode_err     (decode_err),
		.ex_base        (ex_base),
		.ex_imm         (ex_imm),
		.ex_sub         (ex_sub),
		.ex_rd_addr     (ex_rd_addr),
		.ex_write_en    (ex_write_en),
		.ex_load        (ex_load),
		.ex_store       (ex_store),
		.ex_store_value (ex_store_value)
	);

	register_file u_register_file (
		.clk      (clk),
		.run      (run),
		.rn_addr  (rn_addr),
		.rt_addr  (rt_addr),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rn_value (rn_value),
		.rt_value (rt_value)
	);

	execute_unit u_execute_unit (
		.clk               (clk),
		.nreset            (nreset),
		.run               (run),
		.ex_base           (ex_base),
		.ex_imm            (ex_imm),
		.ex_sub            (ex_sub),
		.ex_rd_addr        (ex_rd_addr),
		.ex_write_en       (ex_write_en),
		.ex_load           (ex_load),
		.ex_store          (ex_store),
		.ex_store_value    (ex_store_value),
		.data_memory_a     (data_memory_a),
		.data_memory_out_v (data_memory_out_v),
		.data_memory_s     (data_memory_s),
		.data_memory_read  (data_memory_read),
		.data_memory_write (data_memory_write),
		.mem_rd_addr       (mem_rd_addr),
		.mem_write_en      (mem_write_en),
		.mem_load          (mem_load),
		.mem_result        (mem_result)
	);

	writeback_unit u_writeback_unit (
		.clk              (clk),
		.nreset           (nreset),
		.run              (run),
		.mem_rd_addr      (mem_rd_addr),
		.mem_write_en     (mem_write_en),
		.mem_load         (mem_load),
		.mem_result       (mem_result),
		.data_memory_in_v (data_memory_in_v),
		.wr_en            (wr_en),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data)
	);

endmodule

// File: rtl/writeback_unit.sv
//----------------------------------------------------------
// Load data sampled in the cycle after the read strobe
// Read data must stay valid while clk_en is held low
//----------------------------------------------------------
module writeback_unit (
	input  logic                clk,
	input  logic                nreset,
	input  logic                run,
	input  core_pkg::reg_addr_t mem_rd_addr,
	input  logic                mem_write_en,
	input  logic                mem_load,
	input  core_pkg::xlen_t     mem_result,
	input  core_pkg::xlen_t     data_memory_in_v,
	output logic                wr_en,
	output core_pkg::reg_addr_t wr_addr,
	output core_pkg::xlen_t     wr_data
);

	logic            wb_load;
	core_pkg::xlen_t wb_result;

	// Memory to writeback controls
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			wr_en   <= 1'b0;
			wb_load <= 1'b0;
		end else if (run) begin
			wr_en   <= mem_write_en;
			wb_load <= mem_load;
		end
	end

	always_ff @(posedge clk) begin
		if (run) begin
			wr_addr   <= mem_rd_addr;
			wb_result <= mem_result;
		end
	end

	// Loaded word or adder result
	assign wr_data = wb_load ? data_memory_in_v : wb_result;

endmodule

// File: rtl/execute_unit.sv
//----------------------------------------------------------
// One adder gives both ALU result and memory address
// Memory stage registers drive the data port directly
//----------------------------------------------------------
module execute_unit (
	input  logic                clk,
	input  logic                nreset,
	input  logic                run,
	input  core_pkg::xlen_t     ex_base,
	input  core_pkg::xlen_t     ex_imm,
	input  logic                ex_sub,
	input  core_pkg::reg_addr_t ex_rd_addr,
	input  logic                ex_write_en,
	input  logic                ex_load,
	input  logic                ex_store,
	input  core_pkg::xlen_t     ex_store_value,
	output core_pkg::xlen_t     data_memory_a,
	output core_pkg::xlen_t     data_memory_out_v,
	output core_pkg::mem_size_t data_memory_s,
	output logic                data_memory_read,
	output logic                data_memory_write,
	output core_pkg::reg_addr_t mem_rd_addr,
	output logic                mem_write_en,
	output logic                mem_load,
	output core_pkg::xlen_t     mem_result
);

	core_pkg::xlen_t sum;
	logic            load_q;

	// Base plus or minus immediate
	assign sum = ex_sub ? (ex_base - ex_imm) : (ex_base + ex_imm);

	//----------------------------------------------------------
	// Execute to memory registers
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			load_q            <= 1'b0;
			data_memory_write <= 1'b0;
			mem_write_en      <= 1'b0;
		end else if (run) begin
			load_q            <= ex_load;
			data_memory_write <= ex_store;
			mem_write_en      <= ex_write_en;
		end
	end

	always_ff @(posedge clk) begin
		if (run) begin
			mem_result        <= sum;
			data_memory_out_v <= ex_store_value;
			mem_rd_addr       <= ex_rd_addr;
		end
	end

	// Memory stage port
	assign data_memory_a    = mem_result;
	assign data_memory_read = load_q;
	// Doubleword accesses only
	assign data_memory_s    = core_pkg::LDST_SIZE_64;

	// Read strobe doubles as the load flag for writeback
	assign mem_load = load_q;

endmodule

// File: rtl/register_file.sv
//----------------------------------------------------------
// x0 to x30 in storage, x31 reads zero and drops writes
// Reads are combinational, no bypass of same-cycle write
//----------------------------------------------------------
module register_file (
	input  logic                clk,
	input  logic                run,
	input  core_pkg::reg_addr_t rn_addr,
	input  core_pkg::reg_addr_t rt_addr,
	input  logic                wr_en,
	input  core_pkg::reg_addr_t wr_addr,
	input  core_pkg::xlen_t     wr_data,
	output core_pkg::xlen_t     rn_value,
	output core_pkg::xlen_t     rt_value
);

	core_pkg::xlen_t regs [0:core_pkg::NUM_REGS-1];

	// Write on the edge, frozen while the pipeline is stopped
	always_ff @(posedge clk) begin
		if (run && wr_en && (wr_addr != core_pkg::ZERO_REG)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Zero register override
	assign rn_value = (rn_addr == core_pkg::ZERO_REG) ? '0 : regs[rn_addr];
	assign rt_value = (rt_addr == core_pkg::ZERO_REG) ? '0 : regs[rt_addr];

endmodule

// File: rtl/decode_unit.sv
//----------------------------------------------------------
// Decodes 64-bit ADD/SUB imm, LDR/STR uimm and NOP only
// Anything else raises ERR_UNDEF in the same cycle
//----------------------------------------------------------
module decode_unit (
	input  logic                clk,
	input  logic                nreset,
	input  logic                run,
	input  core_pkg::instr_t    instr,
	input  core_pkg::xlen_t     rn_value,
	input  core_pkg::xlen_t     rt_value,
	output core_pkg::reg_addr_t rn_addr,
	output core_pkg::reg_addr_t rt_addr,
	output core_pkg::err_code_t decode_err,
	output core_pkg::xlen_t     ex_base,
	output core_pkg::xlen_t     ex_imm,
	output logic                ex_sub,
	output core_pkg::reg_addr_t ex_rd_addr,
	output logic                ex_write_en,
	output logic                ex_load,
	output logic                ex_store,
	output core_pkg::xlen_t     ex_store_value
);

	logic            is_add;
	logic            is_sub;
	logic            is_ldr;
	logic            is_str;
	logic            is_nop;
	logic [11:0]     imm12;
	logic            imm_sh;
	core_pkg::xlen_t imm;

	//----------------------------------------------------------
	// Encoding match
	assign is_add = (instr & core_pkg::ADD_IMM_MASK) == core_pkg::ADD_IMM_MATCH;
	assign is_sub = (instr & core_pkg::SUB_IMM_MASK) == core_pkg::SUB_IMM_MATCH;
	assign is_ldr = (instr & core_pkg::LDR_MASK) == core_pkg::LDR_MATCH;
	assign is_str = (instr & core_pkg::STR_MASK) == core_pkg::STR_MATCH;
	assign is_nop = instr == core_pkg::INSTR_NOP;

	assign decode_err = (is_add || is_sub || is_ldr || is_str || is_nop) ?
		core_pkg::ERR_NONE : core_pkg::ERR_UNDEF;

	// Rn is the base, Rt is the store source
	assign rn_addr = instr[9:5];
	assign rt_addr = instr[4:0];

	//----------------------------------------------------------
	// Immediate forming
	assign imm12  = instr[21:10];
	// Only meaningful for ADD/SUB, opc bit for loads
	assign imm_sh = instr[22];

	always_comb begin
		imm = core_pkg::xlen_t'(imm12);
		if (is_ldr || is_str) begin
			// Offset counted in doublewords
			imm = imm << core_pkg::LDST_SCALE;
		end else if (imm_sh) begin
			imm = imm << core_pkg::IMM_SHIFT;
		end
	end

	//----------------------------------------------------------
	// Decode to execute registers
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			ex_write_en <= 1'b0;
			ex_load     <= 1'b0;
			ex_store    <= 1'b0;
		end else if (run) begin
			// Loads write back, stores do not
			ex_write_en <= is_add || is_sub || is_ldr;
			ex_load     <= is_ldr;
			ex_store    <= is_str;
		end
	end

	// Operands and destination
	always_ff @(posedge clk) begin
		if (run) begin
			ex_base        <= rn_value;
			ex_imm         <= imm;
			ex_sub         <= is_sub;
			ex_rd_addr     <= instr[4:0];
			ex_store_value <= rt_value;
		end
	end

endmodule

// File: rtl/fetch_unit.sv
//----------------------------------------------------------
// Instruction memory has one cycle of read latency
// First slot after reset release is a NOP bubble
//----------------------------------------------------------
module fetch_unit (
	input  logic                clk,
	input  logic                nreset,
	input  logic                clk_en,
	input  core_pkg::err_code_t decode_err,
	input  core_pkg::instr_t    instruction_memory_v,
	output logic                run,
	output core_pkg::xlen_t     instruction_memory_a,
	output logic                instruction_memory_en,
	output core_pkg::instr_t    instr,
	output logic                instr_pc_valid
);

	logic             nreset_sync;
	core_pkg::pc_t    pc;
	// Copy of the word in decode, used while stalled
	core_pkg::instr_t instr_q;
	logic             hold_q;

	// Release synchroniser and fetch valid flag
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			nreset_sync    <= 1'b0;
			instr_pc_valid <= 1'b0;
			hold_q         <= 1'b0;
		end else begin
			nreset_sync    <= 1'b1;
			instr_pc_valid <= nreset_sync;
			// Memory moves on to the next word during a stall
			hold_q         <= !run;
		end
	end

	always_ff @(posedge clk) begin
		instr_q <= instr;
	end

	// Stop on clock enable, reset or any decode error
	assign run = clk_en && nreset_sync && (decode_err == core_pkg::ERR_NONE);

	//----------------------------------------------------------
	// Program counter, one word per run cycle
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			pc <= '0;
		end else if (run) begin
			pc <= pc + core_pkg::pc_t'(1);
		end
	end

	assign instruction_memory_a  = {pc, 2'b00};
	assign instruction_memory_en = nreset_sync;

	// Held word first, then bubble until fetch data is valid
	assign instr = hold_q ? instr_q :
		(instr_pc_valid ? instruction_memory_v : core_pkg::INSTR_NOP);

endmodule

// File: rtl/core_pkg.sv
//----------------------------------------------------------
// Widths, opcode patterns and codes for the A64 subset core
// Only 64-bit forms of ADD/SUB imm, LDR/STR uimm and NOP
//----------------------------------------------------------
package core_pkg;

	// Datapath and instruction widths
	localparam int unsigned XLEN = 64;
	localparam int unsigned ILEN = 32;

	// Architectural registers held in storage, x31 is implied zero
	localparam int unsigned NUM_REGS = 31;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [ILEN-1:0] instr_t;
	// Word aligned PC, low two bits implied zero
	typedef logic [XLEN-3:0] pc_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [3:0]      err_code_t;
	typedef logic [1:0]      mem_size_t;

	// Error indicator codes
	localparam err_code_t ERR_NONE  = 4'h0;
	localparam err_code_t ERR_UNDEF = 4'h1;

	// Access size field, only doubleword used here
	localparam mem_size_t LDST_SIZE_64 = 2'b11;

	// HINT #0
	localparam instr_t INSTR_NOP = 32'hD503_201F;

	//----------------------------------------------------------
	// Opcode mask and match pairs
	// ADD/SUB imm, sf=1 S=0, bit 22 is the shift flag
	localparam instr_t ADD_IMM_MASK  = 32'hFF80_0000;
	localparam instr_t ADD_IMM_MATCH = 32'h9100_0000;
	localparam instr_t SUB_IMM_MASK  = 32'hFF80_0000;
	localparam instr_t SUB_IMM_MATCH = 32'hD100_0000;
	// LDR/STR unsigned offset, size=11
	localparam instr_t LDR_MASK      = 32'hFFC0_0000;
	localparam instr_t LDR_MATCH     = 32'hF940_0000;
	localparam instr_t STR_MASK      = 32'hFFC0_0000;
	localparam instr_t STR_MATCH     = 32'hF900_0000;

	localparam reg_addr_t ZERO_REG = 5'd31;

	// Offset scale for doubleword accesses
	localparam int unsigned LDST_SCALE = 3;
	// Optional left shift of the ADD/SUB immediate
	localparam int unsigned IMM_SHIFT  = 12;

endpackage
